//--- rtl/fir_pkg.sv
package fir_pkg;

    localparam int DATA_W   = 32;
    localparam int ADDR_W   = 12;
    localparam int MAX_TAPS = 16;

    // product and accumulate stages still in flight after a sweep
    localparam int PIPE_DRAIN = 3;

    typedef logic signed [DATA_W-1:0]         data_t;
    typedef logic [ADDR_W-1:0]                addr_t;
    typedef logic [$clog2(MAX_TAPS)-1:0]      tap_idx_t;
    typedef logic [$clog2(MAX_TAPS):0]        tap_cnt_t;
    typedef logic [DATA_W-1:0]                len_t;

    localparam addr_t ADDR_AP_CTRL  = 12'h000;
    localparam addr_t ADDR_DATA_LEN = 12'h010;
    localparam addr_t ADDR_TAP_NUM  = 12'h014;
    localparam addr_t ADDR_TAP_BASE = 12'h080;   // tap k at base + 4k

    localparam data_t BUSY_RDATA = '1;           // tap readback while running

    typedef struct packed {
        len_t     data_len;
        tap_cnt_t tap_num;
    } fir_cfg_t;

    typedef struct packed {
        logic     en;
        tap_idx_t idx;
        data_t    data;
    } tap_wr_t;

    typedef enum logic [1:0] {
        AP_IDLE,
        AP_RUN,
        AP_DONE
    } ap_state_e;

    typedef enum logic [1:0] {ENG_WAIT, ENG_MAC, ENG_DRAIN, ENG_HOLD} eng_state_e;

endpackage

//--- rtl/fir_ctrl_regs.sv
`timescale 1ns/1ps

module fir_ctrl_regs import fir_pkg::*; (
    input  logic     axis_clk,
    input  logic     axis_rst_n,
    input  logic     awvalid,
    input  addr_t    awaddr,
    input  logic     wvalid,
    input  data_t    wdata,
    output logic     awready,
    output logic     wready,
    input  logic     arvalid,
    input  addr_t    araddr,
    output logic     arready,
    output logic     rvalid,
    output data_t    rdata,
    input  logic     rready,
    output logic     run,
    output logic     start,
    input  logic     run_end,
    output fir_cfg_t cfg,
    output tap_wr_t  tap_wr,
    output tap_idx_t tap_ridx,
    input  data_t    tap_rdata
);

    ap_state_e state;
    addr_t     rd_addr;
    addr_t     wr_off;
    addr_t     rd_off;
    logic      cfg_open;
    logic      wr_fire;
    logic      ar_fire;
    logic      wr_is_tap;
    logic      rd_is_tap;
    logic      rd_from_bank;
    logic      tap_wait;
    tap_cnt_t  tap_num_wr;
    data_t     reg_rdata;

    assign cfg_open = (state != AP_RUN);           // idle or done
    assign run      = (state == AP_RUN);
    assign wr_fire  = awvalid && wvalid && !awready;
    assign ar_fire  = arvalid && !arready && !tap_wait && !rvalid;

    // tap window decode for both ports
    assign wr_off    = awaddr - ADDR_TAP_BASE;
    assign rd_off    = rd_addr - ADDR_TAP_BASE;
    assign wr_is_tap = (awaddr >= ADDR_TAP_BASE) && (wr_off < addr_t'(4 * MAX_TAPS));
    assign rd_is_tap = (rd_addr >= ADDR_TAP_BASE) && (rd_off < addr_t'(4 * MAX_TAPS));
    assign rd_from_bank = rd_is_tap && cfg_open;

    assign tap_wr.en   = wr_fire && cfg_open && wr_is_tap;
    assign tap_wr.idx  = wr_off[2 +: $bits(tap_idx_t)];
    assign tap_wr.data = wdata;
    assign tap_ridx    = rd_off[2 +: $bits(tap_idx_t)];

    // counts above capacity saturate
    assign tap_num_wr = (len_t'(wdata) > len_t'(MAX_TAPS)) ? tap_cnt_t'(MAX_TAPS)
                                                             : tap_cnt_t'(wdata);

    always_comb begin
        reg_rdata = '0;
        if (rd_is_tap) begin
            reg_rdata = BUSY_RDATA;                // bank answers when not running
        end else begin
            case (rd_addr)
                ADDR_AP_CTRL: begin
                    reg_rdata[2] = cfg_open;       // ap_idle
                    reg_rdata[1] = (state == AP_DONE);
                end
                ADDR_DATA_LEN: reg_rdata = data_t'(cfg.data_len);
                ADDR_TAP_NUM:  reg_rdata = data_t'(cfg.tap_num);
                default:       reg_rdata = '0;
            endcase
        end
    end

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            state   <= AP_IDLE;
            start   <= 1'b0;
            awready <= 1'b0;
            wready  <= 1'b0;
            cfg     <= '0;
        end else begin
            awready <= wr_fire;
            wready  <= wr_fire;
            start   <= 1'b0;
            if (wr_fire && cfg_open) begin
                case (awaddr)
                    ADDR_AP_CTRL: begin
                        if (wdata[0]) begin
                            start <= 1'b1;
                            state <= AP_RUN;
                        end
                    end
                    ADDR_DATA_LEN: cfg.data_len <= len_t'(wdata);
                    ADDR_TAP_NUM:  cfg.tap_num  <= tap_num_wr;
                    default: ;
                endcase
            end else if (run && run_end) begin
                state <= AP_DONE;
            end
        end
    end

    // arready first and rvalid one or two cycles later
    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            arready  <= 1'b0;
            rvalid   <= 1'b0;
            tap_wait <= 1'b0;
        end else begin
            arready  <= ar_fire;
            tap_wait <= arready && rd_from_bank;
            if ((arready && !rd_from_bank) || tap_wait) begin
                rvalid <= 1'b1;
            end else if (rvalid && rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge axis_clk) begin
        if (ar_fire) begin
            rd_addr <= araddr;
        end
        if (tap_wait) begin
            rdata <= tap_rdata;                    // registered bank word
        end else if (arready) begin
            rdata <= reg_rdata;
        end
    end

endmodule

//--- rtl/fir_tap_bank.sv
`timescale 1ns/1ps

module fir_tap_bank import fir_pkg::*; (
    input  logic     axis_clk,
    input  logic     axis_rst_n,
    input  tap_wr_t  tap_wr,
    input  tap_idx_t mac_idx,
    input  tap_idx_t host_idx,
    output data_t    mac_coef,
    output data_t    host_coef
);

    data_t taps [MAX_TAPS];

    // coefficients start out as zero after reset
    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            for (int i = 0; i < MAX_TAPS; i++) begin
                taps[i] <= '0;
            end
        end else if (tap_wr.en) begin
            taps[tap_wr.idx] <= tap_wr.data;
        end
    end

    // two independent read ports, one cycle latency each
    always_ff @(posedge axis_clk) begin
        mac_coef  <= taps[mac_idx];                // engine operand
        host_coef <= taps[host_idx];               // register readback
    end

endmodule

//--- rtl/fir_sample_window.sv
`timescale 1ns/1ps

module fir_sample_window import fir_pkg::*; (
    input  logic     axis_clk,
    input  logic     axis_rst_n,
    input  logic     run,
    input  logic     start,
    input  logic     ss_tvalid,
    input  data_t    ss_tdata,
    output logic     ss_tready,
    output logic     sample_valid,
    input  logic     sample_take,
    input  tap_idx_t hist_idx,
    output data_t    hist_sample
);

    data_t    ring [MAX_TAPS];
    data_t    buf_data;
    tap_idx_t head;                                // newest entry
    tap_idx_t head_nxt;
    tap_cnt_t fill;                                // samples stored since start
    logic     accept;

    assign ss_tready = run && !sample_valid;
    assign accept    = ss_tvalid && ss_tready;
    assign head_nxt  = head + 1'b1;

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            sample_valid <= 1'b0;
            head         <= '0;
            fill         <= '0;
        end else if (start) begin
            sample_valid <= accept;                // drop any stale entry
            fill         <= '0;
        end else if (accept) begin
            sample_valid <= 1'b1;
        end else if (sample_take) begin
            sample_valid <= 1'b0;
            head         <= head_nxt;
            if (fill != tap_cnt_t'(MAX_TAPS)) begin
                fill <= fill + 1'b1;
            end
        end
    end

    always_ff @(posedge axis_clk) begin
        if (accept) begin
            buf_data <= ss_tdata;
        end
        if (sample_take && !start) begin
            ring[head_nxt] <= buf_data;
        end
        // offsets past the fill count read as zero history
        if (tap_cnt_t'(hist_idx) < fill) begin
            hist_sample <= ring[head - hist_idx];
        end else begin
            hist_sample <= '0;
        end
    end

endmodule

//--- rtl/fir_mac_engine.sv
`timescale 1ns/1ps

module fir_mac_engine import fir_pkg::*; (
    input  logic     axis_clk,
    input  logic     axis_rst_n,
    input  logic     start,
    input  fir_cfg_t cfg,
    input  logic     sample_valid,
    input  data_t    mac_coef,
    input  data_t    hist_sample,
    input  logic     sm_tready,
    output logic     sample_take,
    output tap_idx_t mac_idx,
    output tap_idx_t hist_idx,
    output logic     sm_tvalid,
    output data_t    sm_tdata,
    output logic     sm_tlast,
    output logic     run_end
);

    eng_state_e state;
    tap_idx_t   k;                                 // sweep index, then drain count
    len_t       out_cnt;
    logic       op_v;                              // operands from bank/window valid
    logic       prod_v;
    data_t      prod;
    data_t      acc;
    logic       more_data;
    logic       sweep_last;
    logic       drain_last;
    logic       load_out;
    logic       out_fire;

    assign more_data   = out_cnt < cfg.data_len;
    assign sample_take = (state == ENG_WAIT) && sample_valid && more_data && !start;
    assign sweep_last  = (tap_cnt_t'(k) + 1'b1) == cfg.tap_num;
    assign drain_last  = (k == tap_idx_t'(PIPE_DRAIN - 1));
    assign load_out    = (state == ENG_DRAIN) && drain_last && !start;
    assign out_fire    = sm_tvalid && sm_tready;
    assign mac_idx     = k;
    assign hist_idx    = k;                        // same offset to both sources

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            state     <= ENG_WAIT;
            k         <= '0;
            out_cnt   <= '0;
            op_v      <= 1'b0;
            prod_v    <= 1'b0;
            sm_tvalid <= 1'b0;
            sm_tlast  <= 1'b0;
            run_end   <= 1'b0;
        end else begin
            op_v    <= (state == ENG_MAC);
            prod_v  <= op_v;
            run_end <= out_fire && sm_tlast;
            if (start) begin
                state     <= ENG_WAIT;
                k         <= '0;
                out_cnt   <= '0;
                sm_tvalid <= 1'b0;
                sm_tlast  <= 1'b0;
            end else begin
                case (state)
                    ENG_WAIT: begin
                        if (sample_take) begin
                            k     <= '0;
                            state <= (cfg.tap_num == '0) ? ENG_DRAIN : ENG_MAC;
                        end
                    end
                    ENG_MAC: begin
                        if (sweep_last) begin
                            k     <= '0;
                            state <= ENG_DRAIN;
                        end else begin
                            k <= k + 1'b1;
                        end
                    end
                    ENG_DRAIN: begin
                        if (drain_last) begin
                            state     <= ENG_HOLD;
                            sm_tvalid <= 1'b1;
                            sm_tlast  <= (out_cnt + 1'b1) == cfg.data_len;
                        end else begin
                            k <= k + 1'b1;
                        end
                    end
                    ENG_HOLD: begin
                        if (out_fire) begin
                            state     <= ENG_WAIT;
                            sm_tvalid <= 1'b0;
                            sm_tlast  <= 1'b0;
                            out_cnt   <= out_cnt + 1'b1;
                        end
                    end
                    default: state <= ENG_WAIT;
                endcase
            end
        end
    end

    // datapath wraps at 32 bits
    always_ff @(posedge axis_clk) begin
        if (op_v) begin
            prod <= mac_coef * hist_sample;
        end
        if (sample_take) begin
            acc <= '0;
        end else if (prod_v) begin
            acc <= acc + prod;
        end
        if (load_out) begin
            sm_tdata <= acc;                       // held until accepted
        end
    end

endmodule

//--- rtl/fir_top.sv
`timescale 1ns/1ps

module fir_top import fir_pkg::*; (
    input  logic  axis_clk,
    input  logic  axis_rst_n,

    input  logic  awvalid,
    input  addr_t awaddr,
    input  logic  wvalid,
    input  data_t wdata,
    output logic  awready,
    output logic  wready,

    input  logic  arvalid,
    input  addr_t araddr,
    output logic  arready,
    output logic  rvalid,
    output data_t rdata,
    input  logic  rready,

    input  logic  ss_tvalid,
    input  data_t ss_tdata,
    output logic  ss_tready,

    output logic  sm_tvalid,
    output data_t sm_tdata,
    output logic  sm_tlast,
    input  logic  sm_tready
);

    logic     run;
    logic     start;
    logic     run_end;
    fir_cfg_t cfg;
    tap_wr_t  tap_wr;
    tap_idx_t tap_ridx;
    data_t    tap_rdata;
    tap_idx_t mac_idx;
    tap_idx_t hist_idx;
    data_t    mac_coef;
    data_t    hist_sample;
    logic     sample_valid;
    logic     sample_take;

    fir_ctrl_regs u_ctrl (
        .axis_clk   (axis_clk),
        .axis_rst_n (axis_rst_n),
        .awvalid    (awvalid),
        .awaddr     (awaddr),
        .wvalid     (wvalid),
        .wdata      (wdata),
        .awready    (awready),
        .wready     (wready),
        .arvalid    (arvalid),
        .araddr     (araddr),
        .arready    (arready),
        .rvalid     (rvalid),
        .rdata      (rdata),
        .rready     (rready),
        .run        (run),
        .start      (start),
        .run_end    (run_end),
        .cfg        (cfg),
        .tap_wr     (tap_wr),
        .tap_ridx   (tap_ridx),
        .tap_rdata  (tap_rdata)
    );

    fir_tap_bank u_taps (
        .axis_clk   (axis_clk),
        .axis_rst_n (axis_rst_n),
        .tap_wr     (tap_wr),
        .mac_idx    (mac_idx),
        .host_idx   (tap_ridx),
        .mac_coef   (mac_coef),
        .host_coef  (tap_rdata)
    );

    fir_sample_window u_window (
        .axis_clk     (axis_clk),
        .axis_rst_n   (axis_rst_n),
        .run          (run),
        .start        (start),
        .ss_tvalid    (ss_tvalid),
        .ss_tdata     (ss_tdata),
        .ss_tready    (ss_tready),
        .sample_valid (sample_valid),
        .sample_take  (sample_take),
        .hist_idx     (hist_idx),
        .hist_sample  (hist_sample)
    );

    fir_mac_engine u_engine (
        .axis_clk     (axis_clk),
        .axis_rst_n   (axis_rst_n),
        .start        (start),
        .cfg          (cfg),
        .sample_valid (sample_valid),
        .mac_coef     (mac_coef),
        .hist_sample  (hist_sample),
        .sm_tready    (sm_tready),
        .sample_take  (sample_take),
        .mac_idx      (mac_idx),
        .hist_idx     (hist_idx),
        .sm_tvalid    (sm_tvalid),
        .sm_tdata     (sm_tdata),
        .sm_tlast     (sm_tlast),
        .run_end      (run_end)
    );

endmodule

//--- test/fir_asserts.sv
`timescale 1ns/1ps

module fir_asserts import fir_pkg::*; (
    input logic  axis_clk,
    input logic  axis_rst_n,
    input logic  start,
    input logic  run_end,
    input logic  ss_tready,
    input logic  sm_tvalid,
    input logic  sm_tready,
    input data_t sm_tdata,
    input logic  sm_tlast,
    input logic  rvalid,
    input logic  rready
);

    logic in_run;                                  // from start pulse until run_end

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            in_run <= 1'b0;
        end else if (start) begin
            in_run <= 1'b1;
        end else if (run_end) begin
            in_run <= 1'b0;
        end
    end

    // output word held while the sink stalls
    a_out_stable: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
        sm_tvalid && !sm_tready |=> sm_tvalid && $stable(sm_tdata) && $stable(sm_tlast))
        else $error("stream output changed while stalled");

    a_rvalid_hold: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
        rvalid && !rready |=> rvalid)
        else $error("rvalid dropped before rready");

    // no input accepted outside a run
    a_no_ready_idle: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
        !(start || in_run) |-> !ss_tready)
        else $error("ss_tready high while not running");

    a_quiet_after_reset: assert property (@(posedge axis_clk)
        $rose(axis_rst_n) |-> !sm_tvalid [*4])
        else $error("sm_tvalid high right after reset");

endmodule

bind fir_top fir_asserts u_asserts (
    .axis_clk   (axis_clk),
    .axis_rst_n (axis_rst_n),
    .start      (start),
    .run_end    (run_end),
    .ss_tready  (ss_tready),
    .sm_tvalid  (sm_tvalid),
    .sm_tready  (sm_tready),
    .sm_tdata   (sm_tdata),
    .sm_tlast   (sm_tlast),
    .rvalid     (rvalid),
    .rready     (rready)
);

//--- test/tb_fir.sv
`timescale 1ns/1ps

module tb_fir import fir_pkg::*; ();

    logic        axis_clk;
    logic        axis_rst_n;
    logic        awvalid;
    addr_t       awaddr;
    logic        wvalid;
    data_t       wdata;
    logic        awready;
    logic        wready;
    logic        arvalid;
    addr_t       araddr;
    logic        arready;
    logic        rvalid;
    data_t       rdata;
    logic        rready;
    logic        ss_tvalid;
    data_t       ss_tdata;
    logic        ss_tready;
    logic        sm_tvalid;
    data_t       sm_tdata;
    logic        sm_tlast;
    logic        sm_tready;
    logic [31:0] stim [0:63];
    logic [31:0] lfsr;
    int          errors;
    int          tests;
    int          ptr;
    int          e0;

    fir_top dut_i (.*);

    initial begin
        axis_clk = 1'b0;
        forever #5 axis_clk = ~axis_clk;
    end

    initial begin
        #200us;
        $display("simulation did not finish in time");
        $display("TEST FAILED");
        $finish;
    end

    // galois lfsr stepped once per bit taken
    function int random_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
            v = (v << 1) | int'(lfsr[0]);
        end
        return v;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("FAIL %s expected %h actual %h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int first_err);
        tests++;
        $display("%s: %s", name, (errors == first_err) ? "pass" : "fail");
    endtask

    task automatic reg_write(input addr_t addr, input data_t data);
        int waited;
        waited = 0;
        @(posedge axis_clk);
        awvalid <= 1'b1;
        wvalid  <= 1'b1;
        awaddr  <= addr;
        wdata   <= data;
        do begin
            @(negedge axis_clk);
            waited++;
        end while (!(awready && wready) && waited < 50);
        if (!(awready && wready)) begin
            $display("timeout waiting for the write handshake at address %h", addr);
            errors++;
        end
        @(posedge axis_clk);
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
    endtask

    task automatic reg_read(input addr_t addr, output data_t data);
        int waited;
        waited = 0;
        @(posedge axis_clk);
        arvalid <= 1'b1;
        araddr  <= addr;
        rready  <= 1'b1;
        do begin
            @(negedge axis_clk);
            waited++;
        end while (!arready && waited < 50);
        if (!arready) begin
            $display("timeout waiting for arready at address %h", addr);
            errors++;
        end
        @(posedge axis_clk);
        arvalid <= 1'b0;
        waited = 0;
        do begin
            @(negedge axis_clk);
            waited++;
        end while (!rvalid && waited < 50);
        if (!rvalid) begin
            $display("timeout waiting for read data at address %h", addr);
            errors++;
        end
        data = rdata;                              // stable while rvalid
        @(posedge axis_clk);
        rready <= 1'b0;
    endtask

    task automatic check_read(input string name, input addr_t addr, input data_t expected);
        data_t value;
        reg_read(addr, value);
        check_value(name, expected, value);
    endtask

    task automatic send_samples(input int n, input int base);
        int waited;
        for (int i = 0; i < n; i++) begin
            repeat (random_bits(2)) @(posedge axis_clk);   // random gap
            @(posedge axis_clk);
            ss_tvalid <= 1'b1;
            ss_tdata  <= stim[base + i];
            waited = 0;
            do begin
                @(negedge axis_clk);
                waited++;
            end while (!ss_tready && waited < 500);
            if (!ss_tready) begin
                $display("timeout waiting for ss_tready on sample %0d", i);
                errors++;
            end
            @(posedge axis_clk);
            ss_tvalid <= 1'b0;
        end
    endtask

    task automatic recv_outputs(input int run_no, input int n, input int base);
        int got;
        int waited;
        int extra;
        got = 0;
        waited = 0;
        extra = 0;
        while (got < n && waited < 1000) begin
            @(posedge axis_clk);
            sm_tready <= (random_bits(2) != 0);    // stall about one cycle in four
            @(negedge axis_clk);
            waited++;
            if (sm_tvalid && sm_tready) begin
                check_value($sformatf("run%0d_out%0d", run_no, got), stim[base + got], sm_tdata);
                check_value($sformatf("run%0d_last%0d", run_no, got),
                            32'(got == n - 1), 32'(sm_tlast));
                got++;
                waited = 0;
            end
        end
        if (got < n) begin
            $display("timeout waiting for output %0d of run %0d", got, run_no);
            errors++;
        end
        @(posedge axis_clk);
        sm_tready <= 1'b1;
        repeat (30) begin
            @(negedge axis_clk);
            if (sm_tvalid) begin
                extra++;
            end
        end
        check_value($sformatf("run%0d_count", run_no), 32'(n), 32'(got + extra));
        @(posedge axis_clk);
        sm_tready <= 1'b0;
    endtask

    task automatic do_run(input int run_no);
        int    taps;
        int    len;
        int    base_x;
        int    base_y;
        int    first_err;
        int    polls;
        data_t value;
        taps   = int'(stim[ptr]);
        len    = int'(stim[ptr + 1]);
        base_x = ptr + 2 + taps;
        base_y = base_x + len;
        first_err = errors;
        reg_write(ADDR_DATA_LEN, data_t'(len));
        reg_write(ADDR_TAP_NUM, data_t'(taps));
        for (int k = 0; k < taps; k++) begin
            reg_write(addr_t'(ADDR_TAP_BASE + 4 * k), stim[ptr + 2 + k]);
        end
        check_read("data_len readback", ADDR_DATA_LEN, data_t'(len));
        check_read("tap_num readback", ADDR_TAP_NUM, data_t'(taps));
        for (int k = 0; k < taps; k++) begin
            check_read($sformatf("tap%0d readback", k), addr_t'(ADDR_TAP_BASE + 4 * k),
                       stim[ptr + 2 + k]);
        end
        report_test($sformatf("run %0d config readback", run_no), first_err);

        first_err = errors;
        reg_write(ADDR_AP_CTRL, 32'd1);
        check_read("ap_ctrl running", ADDR_AP_CTRL, 32'd0);
        check_read("tap read while busy", ADDR_TAP_BASE, 32'hffff_ffff);
        reg_write(ADDR_TAP_NUM, 32'd7);            // must be ignored
        report_test($sformatf("run %0d busy status", run_no), first_err);

        first_err = errors;
        fork
            send_samples(len, base_x);
            recv_outputs(run_no, len, base_y);
        join
        report_test($sformatf("run %0d stream outputs", run_no), first_err);

        first_err = errors;
        polls = 0;
        do begin
            reg_read(ADDR_AP_CTRL, value);
            polls++;
        end while (value != 32'd6 && polls < 40);
        check_value("ap_ctrl done", 32'd6, value);
        check_read("tap_num after run", ADDR_TAP_NUM, data_t'(taps));
        report_test($sformatf("run %0d done status", run_no), first_err);
        ptr = base_y + len;
    endtask

    initial begin
        axis_rst_n = 1'b0;
        awvalid    = 1'b0;
        awaddr     = '0;
        wvalid     = 1'b0;
        wdata      = '0;
        arvalid    = 1'b0;
        araddr     = '0;
        rready     = 1'b0;
        ss_tvalid  = 1'b0;
        ss_tdata   = '0;
        sm_tready  = 1'b0;
        lfsr       = 32'h133e_358a;
        errors     = 0;
        tests      = 0;
        ptr        = 0;
        $readmemh("test/fir_stim.txt", stim);
        repeat (4) @(posedge axis_clk);
        axis_rst_n <= 1'b1;

        e0 = errors;
        check_read("ap_ctrl after reset", ADDR_AP_CTRL, 32'd4);
        report_test("reset idle", e0);
        do_run(1);
        do_run(2);                                 // restarts from done

        $display("%0d tests run, %0d errors", tests, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- test/fir_stim.txt
// per run: tap count, data length, taps, input samples, expected outputs
// one 32-bit hex word per line, runs follow each other
// run 1
00000004
00000006
00000001 00000002 ffffffff 00000003
00000005 0000000a fffffffe 00000007 00000000 00000004
00000005 00000014 0000000d 00000008 0000002e fffffff7
// run 2, history must start from zero again
00000003
00000004
00000003 fffffffe 00000001
00000001 00000002 00000003 00000004
00000003 00000004 00000006 00000008

//--- src.f
rtl/fir_pkg.sv
rtl/fir_ctrl_regs.sv
rtl/fir_tap_bank.sv
rtl/fir_sample_window.sv
rtl/fir_mac_engine.sv
rtl/fir_top.sv
test/fir_asserts.sv
test/tb_fir.sv

//--- run.sh
#!/bin/sh
# build and run from the project root
verilator --binary --timing --assert --top-module tb_fir -f src.f -o sim_fir \
    && ./obj_dir/sim_fir | tee /dev/stderr | grep -q "^TEST OK$" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
